// File: logic/shim_consts.svh
// Host shim constants that set the field widths and the reserved mdata mark for walker traffic
`ifndef SHIM_CONSTS_SVH
`define SHIM_CONSTS_SVH

// ======================================================================
// Field widths
// ======================================================================

// Width of the metadata field carried with every read request and response
`define SHIM_MDATA_W 16

// Width of a cache-line address on the host read-request channel
`define SHIM_CL_ADDR_W 42

// Width of the data carried by a single read response
`define SHIM_CL_DATA_W 64

// Width of the walker's own request tag, which lives in the low mdata bits
`define SHIM_PT_TAG_W 4

// ======================================================================
// Reserved mdata mark
// ======================================================================

// The top mdata bit is reserved to identify traffic owned by the shim
`define SHIM_MDATA_TAG_MASK ({1'b1, {(`SHIM_MDATA_W-1){1'b0}}})

// Masked bits must equal this value for a request or response to be shim traffic
// With a single-bit mask the value simply sets that bit
`define SHIM_MDATA_TAG_VALUE (`SHIM_MDATA_TAG_MASK)

`endif

// File: logic/host_shim_pkg.sv
// Host shim package with the shared data types of the read-channel walker shim
`default_nettype none

`include "shim_consts.svh"

package host_shim_pkg;

    // ==================================================================
    // Channel field types
    // ==================================================================

    // Metadata that travels with a request and comes back with its response
    // The AFU owns every bit except the reserved mark
    typedef logic [`SHIM_MDATA_W-1:0] mdata_t;

    // Cache-line address as seen on the host request channel
    typedef logic [`SHIM_CL_ADDR_W-1:0] cl_addr_t;

    // Payload of one read response
    typedef logic [`SHIM_CL_DATA_W-1:0] cl_data_t;

    // ==================================================================
    // Walker types
    // ==================================================================

    // Tag chosen by the page table walker for its own read
    // It rides in the low mdata bits underneath the reserved mark
    // and comes back unchanged on the matching response
    typedef logic [`SHIM_PT_TAG_W-1:0] pt_tag_t;

endpackage

`default_nettype wire

// File: logic/pt_req_if.sv
// Walker request interface that carries one pending walker read from the slot to the merger
`timescale 1ns/1ps
`default_nettype none

interface pt_req_if;

    // A walker read is held and waiting for a free cycle on the host channel
    logic                     pending;

    // Cache-line address of the held read
    host_shim_pkg::cl_addr_t  addr;

    // Walker tag of the held read
    host_shim_pkg::pt_tag_t   tag;

    // The merger placed the held read on the host channel in this cycle
    // Only ever high for one cycle and only while pending is high
    logic                     emit;

    // The slot owns the request and learns when it has been sent
    modport slot (
        output pending,
        output addr,
        output tag,
        input  emit
    );

    // The merger sees the request and reports when it sent it
    modport merge (
        input  pending,
        input  addr,
        input  tag,
        output emit
    );

endinterface

`default_nettype wire

// File: logic/pt_req_slot.sv
// Walker request slot that holds a single page table read until the merger sends it
`timescale 1ns/1ps
`default_nettype none

module pt_req_slot (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    input  wire logic                     pt_read_en,
    input  wire host_shim_pkg::cl_addr_t  pt_read_addr,
    input  wire host_shim_pkg::pt_tag_t   pt_read_tag,
    output logic                          pt_read_rdy,
    pt_req_if.slot                        req
);

    // Control state of the slot
    logic                     pending_q;

    // Payload of the held request
    host_shim_pkg::cl_addr_t  addr_q;
    host_shim_pkg::pt_tag_t   tag_q;

    // ==================================================================
    // Pending flag
    // ==================================================================

    // The flag drops on the edge after the merger emits the request
    // A new request from the walker sets it on the edge that accepts it
    // The walker only asks while ready is high, so both never collide
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pending_q <= 1'b0;
        end
        else
        begin
            pending_q <= (pending_q & ~req.emit) | pt_read_en;
        end
    end

    // Address and tag are captured together with the request
    always_ff @(posedge clk)
    begin
        if (pt_read_en)
        begin
            addr_q <= pt_read_addr;
            tag_q  <= pt_read_tag;
        end
    end

    // The slot is free whenever nothing is held
    assign pt_read_rdy = ~pending_q;

    // Present the held request to the merger
    assign req.pending = pending_q;
    assign req.addr    = addr_q;
    assign req.tag     = tag_q;

endmodule

`default_nettype wire

// File: logic/c0_req_merge.sv
// Read request merger that injects walker reads into the AFU stream and flags mark misuse
`timescale 1ns/1ps
`default_nettype none

`include "shim_consts.svh"

module c0_req_merge (
    input  wire logic                     clk,
    input  wire logic                     reset_n,
    pt_req_if.merge                       req,
    input  wire logic                     afu_c0_valid,
    input  wire host_shim_pkg::cl_addr_t  afu_c0_addr,
    input  wire host_shim_pkg::mdata_t    afu_c0_mdata,
    input  wire logic                     fiu_c0_alm_full,
    output logic                          fiu_c0_valid,
    output host_shim_pkg::cl_addr_t       fiu_c0_addr,
    output host_shim_pkg::mdata_t         fiu_c0_mdata,
    output logic                          error
);

    // The walker read goes out in this cycle
    logic                   emit;

    // Mdata for the injected read with the reserved mark set
    host_shim_pkg::mdata_t  pt_mdata;

    // The AFU has placed a request that carries the reserved mark
    logic                   afu_uses_mark;

    // Sticky misuse flag
    logic                   error_q;

    // ==================================================================
    // Injection
    // ==================================================================

    // A held walker read takes a slot only when the AFU leaves the
    // channel idle and the host can still accept traffic
    // The AFU is throttled by almost-full while the read is held, so
    // this slot normally appears within a few cycles
    assign emit = req.pending & ~afu_c0_valid & ~fiu_c0_alm_full;

    // The walker tag fills the low bits and the mark fills the top bit
    assign pt_mdata = `SHIM_MDATA_TAG_VALUE | host_shim_pkg::mdata_t'(req.tag);

    // AFU traffic passes untouched unless the walker read is chosen
    always_comb
    begin
        fiu_c0_valid = afu_c0_valid;
        fiu_c0_addr  = afu_c0_addr;
        fiu_c0_mdata = afu_c0_mdata;

        if (emit)
        begin
            fiu_c0_valid = 1'b1;
            fiu_c0_addr  = req.addr;
            fiu_c0_mdata = pt_mdata;
        end
    end

    // Tell the slot that its request has left
    assign req.emit = emit;

    // ==================================================================
    // Reserved mark check
    // ==================================================================

    // The AFU must never set the reserved bits to the mark value
    // Otherwise its responses would be stolen by the walker
    assign afu_uses_mark = afu_c0_valid &
        ((afu_c0_mdata & `SHIM_MDATA_TAG_MASK) == `SHIM_MDATA_TAG_VALUE);

    // Once set the flag holds until reset and keeps the AFU blocked
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            error_q <= 1'b0;
        end
        else if (afu_uses_mark)
        begin
            error_q <= 1'b1;
        end
    end

    assign error = error_q;

endmodule

`default_nettype wire

// File: logic/c0_rsp_steer.sv
// Read response steerer that routes marked responses to the walker and forms AFU almost-full
`timescale 1ns/1ps
`default_nettype none

`include "shim_consts.svh"

module c0_rsp_steer (
    input  wire logic                     fiu_rsp_valid,
    input  wire host_shim_pkg::cl_data_t  fiu_rsp_data,
    input  wire host_shim_pkg::mdata_t    fiu_rsp_mdata,
    input  wire logic                     fiu_c0_alm_full,
    input  wire logic                     pending,
    input  wire logic                     error,
    output logic                          afu_rsp_valid,
    output host_shim_pkg::cl_data_t       afu_rsp_data,
    output host_shim_pkg::mdata_t         afu_rsp_mdata,
    output logic                          pt_rsp_valid,
    output host_shim_pkg::cl_data_t       pt_rsp_data,
    output host_shim_pkg::pt_tag_t        pt_rsp_tag,
    output logic                          afu_c0_alm_full
);

    // The response answers a read injected for the walker
    logic is_pt_rsp;

    // ==================================================================
    // Response routing
    // ==================================================================

    // Only the reserved bits decide ownership of a response
    assign is_pt_rsp =
        ((fiu_rsp_mdata & `SHIM_MDATA_TAG_MASK) == `SHIM_MDATA_TAG_VALUE);

    // Walker responses are hidden from the AFU
    // Everything else reaches the AFU exactly as the host sent it
    assign afu_rsp_valid = fiu_rsp_valid & ~is_pt_rsp;
    assign afu_rsp_data  = fiu_rsp_data;
    assign afu_rsp_mdata = fiu_rsp_mdata;

    // The walker sees the data and recovers its own tag from the low bits
    assign pt_rsp_valid = fiu_rsp_valid & is_pt_rsp;
    assign pt_rsp_data  = fiu_rsp_data;
    assign pt_rsp_tag   = fiu_rsp_mdata[`SHIM_PT_TAG_W-1:0];

    // ==================================================================
    // Flow control toward the AFU
    // ==================================================================

    // Host back-pressure passes straight through
    // A held walker read forces almost-full so the AFU soon goes idle
    // and leaves a free cycle for injection
    // A set error keeps the AFU stopped until reset
    assign afu_c0_alm_full = fiu_c0_alm_full | pending | error;

endmodule

`default_nettype wire

// File: logic/pt_read_shim.sv
// Page table read shim that passes the host read channel through and injects walker reads
`timescale 1ns/1ps
`default_nettype none

module pt_read_shim (
    input  wire logic                     clk,
    input  wire logic                     reset_n,

    // Walker request
    input  wire logic                     pt_read_en,
    input  wire host_shim_pkg::cl_addr_t  pt_read_addr,
    input  wire host_shim_pkg::pt_tag_t   pt_read_tag,
    output logic                          pt_read_rdy,

    // Walker response
    output logic                          pt_rsp_valid,
    output host_shim_pkg::cl_data_t       pt_rsp_data,
    output host_shim_pkg::pt_tag_t        pt_rsp_tag,

    // AFU read requests
    input  wire logic                     afu_c0_valid,
    input  wire host_shim_pkg::cl_addr_t  afu_c0_addr,
    input  wire host_shim_pkg::mdata_t    afu_c0_mdata,
    output logic                          afu_c0_alm_full,

    // Host read requests
    output logic                          fiu_c0_valid,
    output host_shim_pkg::cl_addr_t       fiu_c0_addr,
    output host_shim_pkg::mdata_t         fiu_c0_mdata,
    input  wire logic                     fiu_c0_alm_full,

    // Host read responses
    input  wire logic                     fiu_rsp_valid,
    input  wire host_shim_pkg::cl_data_t  fiu_rsp_data,
    input  wire host_shim_pkg::mdata_t    fiu_rsp_mdata,

    // AFU read responses
    output logic                          afu_rsp_valid,
    output host_shim_pkg::cl_data_t       afu_rsp_data,
    output host_shim_pkg::mdata_t         afu_rsp_mdata,

    // Sticky misuse of the reserved mark
    output logic                          error
);

    // ==================================================================
    // Walker request path
    // ==================================================================

    // Held walker read shared by the slot and the merger
    pt_req_if req_if ();

    // One-entry buffer between the walker and the host channel
    pt_req_slot u_slot (
        .clk          (clk),
        .reset_n      (reset_n),
        .pt_read_en   (pt_read_en),
        .pt_read_addr (pt_read_addr),
        .pt_read_tag  (pt_read_tag),
        .pt_read_rdy  (pt_read_rdy),
        .req          (req_if.slot)
    );

    // Producer toward the host request channel
    c0_req_merge u_merge (
        .clk             (clk),
        .reset_n         (reset_n),
        .req             (req_if.merge),
        .afu_c0_valid    (afu_c0_valid),
        .afu_c0_addr     (afu_c0_addr),
        .afu_c0_mdata    (afu_c0_mdata),
        .fiu_c0_alm_full (fiu_c0_alm_full),
        .fiu_c0_valid    (fiu_c0_valid),
        .fiu_c0_addr     (fiu_c0_addr),
        .fiu_c0_mdata    (fiu_c0_mdata),
        .error           (error)
    );

    // ==================================================================
    // Response path
    // ==================================================================

    // Consumer of host responses
    // It also needs the pending flag and the error to throttle the AFU
    c0_rsp_steer u_steer (
        .fiu_rsp_valid   (fiu_rsp_valid),
        .fiu_rsp_data    (fiu_rsp_data),
        .fiu_rsp_mdata   (fiu_rsp_mdata),
        .fiu_c0_alm_full (fiu_c0_alm_full),
        .pending         (req_if.pending),
        .error           (error),
        .afu_rsp_valid   (afu_rsp_valid),
        .afu_rsp_data    (afu_rsp_data),
        .afu_rsp_mdata   (afu_rsp_mdata),
        .pt_rsp_valid    (pt_rsp_valid),
        .pt_rsp_data     (pt_rsp_data),
        .pt_rsp_tag      (pt_rsp_tag),
        .afu_c0_alm_full (afu_c0_alm_full)
    );

endmodule

`default_nettype wire

// File: dv/pt_read_shim_tb.sv
// Page table read shim testbench with random traffic, walker reads and concurrent checks
`timescale 1ns/1ps
`default_nettype none

`include "shim_consts.svh"

module pt_read_shim_tb;

    // Test lengths in clock cycles
    localparam int PASS_CYCLES  = 60;
    localparam int INJ_READS    = 12;
    localparam int WAIT_LIMIT   = 40;
    localparam int BP_CYCLES    = 80;
    localparam int RSP_CYCLES   = 60;
    localparam int MARK_CYCLES  = 30;
    localparam int RESET_CYCLES = 5;
    localparam int TOTAL_CYCLES = RESET_CYCLES + PASS_CYCLES + INJ_READS * (WAIT_LIMIT + 1)
                                + BP_CYCLES + WAIT_LIMIT + RSP_CYCLES + MARK_CYCLES + 50;

    localparam host_shim_pkg::mdata_t MASK = `SHIM_MDATA_TAG_MASK;
    localparam host_shim_pkg::mdata_t MARK = `SHIM_MDATA_TAG_VALUE;

    logic clk, reset_n;
    logic pt_read_en, pt_read_rdy, pt_rsp_valid;
    host_shim_pkg::cl_addr_t pt_read_addr;
    host_shim_pkg::pt_tag_t  pt_read_tag, pt_rsp_tag;
    host_shim_pkg::cl_data_t pt_rsp_data;
    logic afu_c0_valid, afu_c0_alm_full, fiu_c0_valid, fiu_c0_alm_full;
    host_shim_pkg::cl_addr_t afu_c0_addr, fiu_c0_addr;
    host_shim_pkg::mdata_t   afu_c0_mdata, fiu_c0_mdata;
    logic fiu_rsp_valid, afu_rsp_valid, error;
    host_shim_pkg::cl_data_t fiu_rsp_data, afu_rsp_data;
    host_shim_pkg::mdata_t   fiu_rsp_mdata, afu_rsp_mdata;

    logic [31:0] rng;
    logic        throttle;
    int          err_count, errs_at_start, tests_passed, tests_failed;
    string       test_name;

    pt_read_shim uut (.*);

    always
    begin
        #10 clk = ~clk;
    end

    // ======================================================================
    // Reference model of the walker slot and the sticky error
    // ======================================================================

    logic                    exp_pending, exp_error, inject_slot, afu_marked, rsp_marked;
    host_shim_pkg::cl_addr_t exp_addr;
    host_shim_pkg::pt_tag_t  exp_tag;
    host_shim_pkg::mdata_t   exp_pt_mdata;

    // A held read leaves in the first cycle with an idle AFU and a host that is not full
    assign inject_slot  = exp_pending & ~afu_c0_valid & ~fiu_c0_alm_full;
    assign exp_pt_mdata = MARK | host_shim_pkg::mdata_t'(exp_tag);
    assign afu_marked   = afu_c0_valid & ((afu_c0_mdata & MASK) == MARK);
    assign rsp_marked   = (fiu_rsp_mdata & MASK) == MARK;

    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            exp_pending <= 1'b0;
            exp_error   <= 1'b0;
        end
        else
        begin
            if (pt_read_en)
                exp_pending <= 1'b1;
            else if (inject_slot)
                exp_pending <= 1'b0;
            if (afu_marked)
                exp_error <= 1'b1;
        end
        if (pt_read_en)
        begin
            exp_addr <= pt_read_addr;
            exp_tag  <= pt_read_tag;
        end
    end

    // ======================================================================
    // Concurrent checks
    // ======================================================================

    task automatic report_error(input string msg);
        err_count = err_count + 1;
        $display("ERR %0t: %s", $time, msg);
    endtask

    a_pass_through: assert property (@(posedge clk) disable iff (!reset_n)
        !exp_pending |-> (fiu_c0_valid == afu_c0_valid && fiu_c0_addr == afu_c0_addr
                          && fiu_c0_mdata == afu_c0_mdata))
        else report_error("host request differs from the AFU request");

    a_inject: assert property (@(posedge clk) disable iff (!reset_n)
        inject_slot |-> (fiu_c0_valid && fiu_c0_addr == exp_addr
                         && fiu_c0_mdata == exp_pt_mdata))
        else report_error("walker read not injected with its address and marked tag");

    // While the read waits the AFU request must still pass untouched
    a_afu_kept: assert property (@(posedge clk) disable iff (!reset_n)
        (exp_pending && !inject_slot) |-> (fiu_c0_valid == afu_c0_valid
            && fiu_c0_addr == afu_c0_addr && fiu_c0_mdata == afu_c0_mdata))
        else report_error("AFU request lost or altered while a walker read waits");

    a_ready: assert property (@(posedge clk) disable iff (!reset_n)
        pt_read_rdy == !exp_pending)
        else report_error("pt_read_rdy does not match the slot state");

    a_alm_full: assert property (@(posedge clk) disable iff (!reset_n)
        afu_c0_alm_full == (fiu_c0_alm_full | exp_pending | exp_error))
        else report_error("afu_c0_alm_full has the wrong value");

    a_rsp_walker: assert property (@(posedge clk) disable iff (!reset_n)
        (fiu_rsp_valid && rsp_marked) |-> (pt_rsp_valid && !afu_rsp_valid
            && pt_rsp_data == fiu_rsp_data
            && pt_rsp_tag == fiu_rsp_mdata[`SHIM_PT_TAG_W-1:0]))
        else report_error("marked response not steered to the walker");

    a_rsp_afu: assert property (@(posedge clk) disable iff (!reset_n)
        (fiu_rsp_valid && !rsp_marked) |-> (afu_rsp_valid && !pt_rsp_valid
            && afu_rsp_data == fiu_rsp_data && afu_rsp_mdata == fiu_rsp_mdata))
        else report_error("unmarked response not passed to the AFU unchanged");

    a_rsp_idle: assert property (@(posedge clk) disable iff (!reset_n)
        !fiu_rsp_valid |-> (!afu_rsp_valid && !pt_rsp_valid))
        else report_error("response valid without a host response");

    a_error: assert property (@(posedge clk) disable iff (!reset_n)
        error == exp_error)
        else report_error("error flag has the wrong value");

    // ======================================================================
    // Stimulus helpers
    // ======================================================================

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x   = rng;
        x   = x ^ (x << 13);
        x   = x ^ (x >> 17);
        x   = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // Sample almost-full mid cycle and move on to 2 ns after the next rising edge
    task automatic next_cycle();
        @(negedge clk);
        throttle = afu_c0_alm_full;
        @(posedge clk);
        #2;
    endtask

    // Random AFU request whose mdata never carries the mark
    task automatic drive_afu(input logic want);
        logic [31:0] hi, lo;
        hi = next_random();
        lo = next_random();
        afu_c0_valid = want;
        afu_c0_addr  = {hi[9:0], lo};
        afu_c0_mdata = hi[31:16] & ~MASK;
    endtask

    task automatic drive_walker_read();
        logic [31:0] hi, lo;
        hi = next_random();
        lo = next_random();
        pt_read_en   = 1'b1;
        pt_read_addr = {lo[9:0], hi};
        pt_read_tag  = lo[31:28];
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = err_count;
    endtask

    task automatic finish_test();
        if (err_count == errs_at_start)
        begin
            tests_passed = tests_passed + 1;
            $display("test %s: passed", test_name);
        end
        else
        begin
            tests_failed = tests_failed + 1;
            $display("test %s: failed, %0d errors", test_name, err_count - errs_at_start);
        end
    endtask

    // Keep light traffic going until the slot is free again
    task automatic wait_slot_free(input int read_no);
        logic [31:0] r;
        int          n;
        n = 0;
        while (!pt_read_rdy && n < WAIT_LIMIT)
        begin
            r = next_random();
            fiu_c0_alm_full = (r[3:2] == 2'b00);
            drive_afu(r[0] & ~throttle);
            next_cycle();
            n = n + 1;
        end
        if (!pt_read_rdy)
        begin
            err_count = err_count + 1;
            $display("Walker read %0d was never sent to the host", read_no);
        end
    endtask

    // ======================================================================
    // Tests
    // ======================================================================

    initial
    begin
        logic [31:0] r, d;
        clk = 1'b0;
        reset_n = 1'b0;
        pt_read_en = 1'b0;
        pt_read_addr = '0;
        pt_read_tag = '0;
        afu_c0_valid = 1'b0;
        afu_c0_addr = '0;
        afu_c0_mdata = '0;
        fiu_c0_alm_full = 1'b0;
        fiu_rsp_valid = 1'b0;
        fiu_rsp_data = '0;
        fiu_rsp_mdata = '0;
        rng = 32'ha023;
        throttle = 1'b0;
        err_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) next_cycle();
        reset_n = 1'b1;

        start_test("pass_through");
        repeat (PASS_CYCLES)
        begin
            r = next_random();
            fiu_c0_alm_full = r[1];
            drive_afu(r[0]);
            next_cycle();
        end
        finish_test();

        start_test("injection");
        for (int i = 0; i < INJ_READS; i++)
        begin
            r = next_random();
            fiu_c0_alm_full = (r[3:2] == 2'b00);
            drive_afu(r[0] & ~throttle);
            drive_walker_read();
            next_cycle();
            pt_read_en = 1'b0;
            wait_slot_free(i);
        end
        finish_test();

        // Host mostly full and an AFU that ignores almost-full
        start_test("back_pressure");
        repeat (BP_CYCLES)
        begin
            r = next_random();
            fiu_c0_alm_full = r[1] | r[2];
            drive_afu(r[0]);
            if (pt_read_rdy && r[5:4] == 2'b00)
                drive_walker_read();
            else
                pt_read_en = 1'b0;
            next_cycle();
        end
        pt_read_en = 1'b0;
        wait_slot_free(INJ_READS);
        finish_test();

        start_test("response_steering");
        afu_c0_valid = 1'b0;
        repeat (RSP_CYCLES)
        begin
            r = next_random();
            d = next_random();
            fiu_rsp_valid = r[0] | r[1];
            fiu_rsp_data  = {d, r};
            fiu_rsp_mdata = r[2] ? (r[31:16] | MARK) : (r[31:16] & ~MASK);
            next_cycle();
        end
        fiu_rsp_valid = 1'b0;
        finish_test();

        // One marked AFU request sets the sticky error and a later reset clears it
        start_test("mark_misuse");
        fiu_c0_alm_full = 1'b0;
        next_cycle();
        drive_afu(1'b1);
        afu_c0_mdata = afu_c0_mdata | MARK;
        next_cycle();
        repeat (10)
        begin
            r = next_random();
            drive_afu(r[0]);
            next_cycle();
        end
        afu_c0_valid = 1'b0;
        reset_n = 1'b0;
        repeat (RESET_CYCLES) next_cycle();
        reset_n = 1'b1;
        repeat (5) next_cycle();
        finish_test();

        $display("Errors %0d, tests passed %0d, tests failed %0d",
                 err_count, tests_passed, tests_failed);
        if (err_count == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the test lengths plus a margin
    initial
    begin
        #(TOTAL_CYCLES * 20);
        $display("Simulation stopped by the watchdog before all tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
logic/host_shim_pkg.sv
logic/pt_req_if.sv
logic/pt_req_slot.sv
logic/c0_req_merge.sv
logic/c0_rsp_steer.sv
logic/pt_read_shim.sv
dv/pt_read_shim_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the shim testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pt_read_shim_tb -Mdir obj_dir -f files.f

output=$(./obj_dir/Vpt_read_shim_tb)
echo "$output"

if echo "$output" | grep -q "^Finished with no errors$"; then
    exit 0
else
    exit 1
fi
